// ==== all.f ====
+incdir+hw
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/bp_tag_table.sv
hw/bp_s1_stage.sv
hw/bp_s2_stage.sv
hw/branch_predictor.sv
tests/bp_clk_gen.sv
tests/bp_props.sv
tests/bp_tb.sv

// ==== hw/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// virtual address width
`define BP_VADDR_W 32

// fetch block, pc low bits are always zero
`define BP_BLOCK_BYTES 16
`define BP_BLOCK_OFF_W 4

// micro-BTB, 8 entries
`define BP_UBTB_IDX_W 3
`define BP_UBTB_TAG_W 8

// main BTB, 32 entries
`define BP_BTB_IDX_W 5
`define BP_BTB_TAG_W 10

`define BP_RESET_PC 32'h8000_0000

`endif

// ==== hw/bp_pkg.sv ====
`include "bp_params.svh"

package bp_pkg;

    // one fetch block prediction
    typedef struct packed {
        logic                   valid;
        logic [`BP_VADDR_W-1:0] start_addr;
        logic [`BP_VADDR_W-1:0] target;
        logic                   taken;
        logic                   redirect;
    } bp_pred_t;

    // micro-BTB keeps the taken target only
    typedef struct packed {
        logic [`BP_VADDR_W-1:0] target;
    } bp_ubtb_entry_t;

    // main BTB adds a 2-bit direction counter
    typedef struct packed {
        logic [`BP_VADDR_W-1:0] target;
        logic [1:0]             ctr;
    } bp_btb_entry_t;

endpackage

// ==== hw/bp_s1_stage.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_s1_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   stall_i,
    input  logic                   squash_i,
    input  logic [`BP_VADDR_W-1:0] squash_target_i,
    input  logic                   s2_redirect_i,
    input  logic [`BP_VADDR_W-1:0] s2_target_i,
    bp_update_if.sink              upd,
    output bp_pkg::bp_pred_t       s1_pred_o
);

    logic [`BP_VADDR_W-1:0] pc_q;
    logic                   started_q;

    logic                   ubtb_hit;
    bp_pkg::bp_ubtb_entry_t ubtb_rd_data;
    bp_pkg::bp_ubtb_entry_t ubtb_wr_data;
    logic                   ubtb_wr_en;
    logic                   ubtb_inv_en;

    logic [`BP_VADDR_W-1:0] fall_through;

    // taken trains a target, not taken drops the entry
    assign ubtb_wr_en          = upd.valid && upd.taken;
    assign ubtb_inv_en         = upd.valid && !upd.taken;
    assign ubtb_wr_data.target = upd.target;

    bp_tag_table #(
        .IDX_W   (`BP_UBTB_IDX_W),
        .TAG_W   (`BP_UBTB_TAG_W),
        .entry_t (bp_pkg::bp_ubtb_entry_t)
    ) u_ubtb (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_pc_i   (pc_q),
        .wr_en_i   (ubtb_wr_en),
        .wr_pc_i   (upd.pc),
        .wr_data_i (ubtb_wr_data),
        .inv_en_i  (ubtb_inv_en),
        .rd_hit_o  (ubtb_hit),
        .rd_data_o (ubtb_rd_data)
    );

    assign fall_through = pc_q + `BP_VADDR_W'(`BP_BLOCK_BYTES);

    always_comb begin
        s1_pred_o.valid      = started_q && !stall_i && !squash_i;
        s1_pred_o.start_addr = pc_q;
        s1_pred_o.target     = ubtb_hit ? ubtb_rd_data.target : fall_through;
        s1_pred_o.taken      = ubtb_hit;
        s1_pred_o.redirect   = 1'b0;
    end

    // one idle cycle after reset before the first valid block
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    // next pc: squash, then stall, then stage-2 override
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `BP_RESET_PC;
        end else if (squash_i) begin
            pc_q <= squash_target_i;
        end else if (stall_i || !started_q) begin
            pc_q <= pc_q;
        end else if (s2_redirect_i) begin
            pc_q <= s2_target_i;
        end else begin
            pc_q <= s1_pred_o.target;
        end
    end

endmodule

// ==== hw/bp_s2_stage.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_s2_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   stall_i,
    input  logic                   squash_i,
    input  bp_pkg::bp_pred_t       s1_pred_i,
    bp_update_if.sink              upd,
    output bp_pkg::bp_pred_t       s2_pred_o,
    output logic                   s2_redirect_o,
    output logic [`BP_VADDR_W-1:0] s2_target_o
);

    bp_pkg::bp_pred_t       s2_q;

    logic                   btb_hit;
    bp_pkg::bp_btb_entry_t  btb_rd_data;
    logic                   upd_hit;
    bp_pkg::bp_btb_entry_t  upd_rd_data;
    bp_pkg::bp_btb_entry_t  btb_wr_data;
    logic                   btb_wr_en;

    logic                   pred_taken;
    logic [`BP_VADDR_W-1:0] pred_target;
    logic                   live;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s2_q <= '0;
        end else if (squash_i || s2_redirect_o) begin
            s2_q <= '0;
        end else if (!stall_i) begin
            s2_q <= s1_pred_i;
        end
    end

    // prediction port
    bp_tag_table #(
        .IDX_W   (`BP_BTB_IDX_W),
        .TAG_W   (`BP_BTB_TAG_W),
        .entry_t (bp_pkg::bp_btb_entry_t)
    ) u_btb (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_pc_i   (s2_q.start_addr),
        .wr_en_i   (btb_wr_en),
        .wr_pc_i   (upd.pc),
        .wr_data_i (btb_wr_data),
        .inv_en_i  (1'b0),
        .rd_hit_o  (btb_hit),
        .rd_data_o (btb_rd_data)
    );

    // copy of the BTB read by the update pc, written identically
    bp_tag_table #(
        .IDX_W   (`BP_BTB_IDX_W),
        .TAG_W   (`BP_BTB_TAG_W),
        .entry_t (bp_pkg::bp_btb_entry_t)
    ) u_btb_upd (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_pc_i   (upd.pc),
        .wr_en_i   (btb_wr_en),
        .wr_pc_i   (upd.pc),
        .wr_data_i (btb_wr_data),
        .inv_en_i  (1'b0),
        .rd_hit_o  (upd_hit),
        .rd_data_o (upd_rd_data)
    );

    // a miss that was not taken leaves the table alone
    assign btb_wr_en = upd.valid && (upd_hit || upd.taken);

    always_comb begin
        btb_wr_data = upd_rd_data;
        if (upd_hit) begin
            if (upd.taken) begin
                btb_wr_data.target = upd.target;
                if (upd_rd_data.ctr != 2'd3) begin
                    btb_wr_data.ctr = upd_rd_data.ctr + 2'd1;
                end
            end else if (upd_rd_data.ctr != 2'd0) begin
                btb_wr_data.ctr = upd_rd_data.ctr - 2'd1;
            end
        end else begin
            // new entry starts weakly taken
            btb_wr_data.target = upd.target;
            btb_wr_data.ctr    = 2'd2;
        end
    end

    assign pred_taken  = btb_hit && btb_rd_data.ctr[1];
    assign pred_target = pred_taken ? btb_rd_data.target
                                    : s2_q.start_addr + `BP_VADDR_W'(`BP_BLOCK_BYTES);

    // stall and squash outrank the override
    assign live          = s2_q.valid && !stall_i && !squash_i;
    assign s2_redirect_o = live && (pred_target != s2_q.target);
    assign s2_target_o   = pred_target;

    always_comb begin
        s2_pred_o.valid      = live;
        s2_pred_o.start_addr = s2_q.start_addr;
        s2_pred_o.target     = pred_target;
        s2_pred_o.taken      = pred_taken;
        s2_pred_o.redirect   = s2_redirect_o;
    end

endmodule

// ==== hw/bp_tag_table.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_tag_table #(
    parameter int  IDX_W   = 3,
    parameter int  TAG_W   = 8,
    parameter type entry_t = logic [`BP_VADDR_W-1:0]
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`BP_VADDR_W-1:0] rd_pc_i,
    input  logic                   wr_en_i,
    input  logic [`BP_VADDR_W-1:0] wr_pc_i,
    input  entry_t                 wr_data_i,
    input  logic                   inv_en_i,
    output logic                   rd_hit_o,
    output entry_t                 rd_data_o
);

    localparam int DEPTH   = 1 << IDX_W;
    localparam int IDX_LO  = `BP_BLOCK_OFF_W;
    localparam int TAG_LO  = IDX_LO + IDX_W;

    logic [DEPTH-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [DEPTH];
    entry_t           data_q [DEPTH];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = rd_pc_i[IDX_LO +: IDX_W];
    assign rd_tag = rd_pc_i[TAG_LO +: TAG_W];
    assign wr_idx = wr_pc_i[IDX_LO +: IDX_W];
    assign wr_tag = wr_pc_i[TAG_LO +: TAG_W];

    // lookup is combinational
    assign rd_hit_o  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rd_data_o = data_q[rd_idx];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end else if (inv_en_i && (tag_q[wr_idx] == wr_tag)) begin
            // only drop the entry that belongs to this block
            valid_q[wr_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= wr_data_i;
        end
    end

endmodule

// ==== hw/bp_update_if.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

interface bp_update_if;

    logic                   valid;
    logic [`BP_VADDR_W-1:0] pc;
    logic [`BP_VADDR_W-1:0] target;
    logic                   taken;

    // commit side
    modport src (
        output valid,
        output pc,
        output target,
        output taken
    );

    // predictor tables
    modport sink (
        input valid,
        input pc,
        input target,
        input taken
    );

endinterface

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module branch_predictor (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   stall_i,
    input  logic                   squash_i,
    input  logic [`BP_VADDR_W-1:0] squash_target_i,
    input  logic                   update_valid_i,
    input  logic [`BP_VADDR_W-1:0] update_pc_i,
    input  logic [`BP_VADDR_W-1:0] update_target_i,
    input  logic                   update_taken_i,
    output logic                   pred_valid_o,
    output logic [`BP_VADDR_W-1:0] pred_start_o,
    output logic [`BP_VADDR_W-1:0] pred_target_o,
    output logic                   pred_taken_o,
    output logic                   pred_redirect_o
);

    bp_pkg::bp_pred_t       s1_pred;
    bp_pkg::bp_pred_t       s2_pred;
    bp_pkg::bp_pred_t       out_pred;
    logic                   s2_redirect;
    logic [`BP_VADDR_W-1:0] s2_target;

    bp_update_if upd_if ();

    // commit-time training
    assign upd_if.valid  = update_valid_i;
    assign upd_if.pc     = update_pc_i;
    assign upd_if.target = update_target_i;
    assign upd_if.taken  = update_taken_i;

    bp_s1_stage u_s1 (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall_i),
        .squash_i        (squash_i),
        .squash_target_i (squash_target_i),
        .s2_redirect_i   (s2_redirect),
        .s2_target_i     (s2_target),
        .upd             (upd_if.sink),
        .s1_pred_o       (s1_pred)
    );

    bp_s2_stage u_s2 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .squash_i      (squash_i),
        .s1_pred_i     (s1_pred),
        .upd           (upd_if.sink),
        .s2_pred_o     (s2_pred),
        .s2_redirect_o (s2_redirect),
        .s2_target_o   (s2_target)
    );

    // stage 2 wins only when it overrides
    assign out_pred = s2_redirect ? s2_pred : s1_pred;

    assign pred_valid_o    = out_pred.valid;
    assign pred_start_o    = out_pred.start_addr;
    assign pred_target_o   = out_pred.target;
    assign pred_taken_o    = out_pred.taken;
    assign pred_redirect_o = out_pred.redirect;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f all.f --top-module bp_tb -o bp_sim

# the simulator may exit non-zero on an assertion, the log decides
./obj_dir/bp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "run ended without a result"
    exit 1
fi
exit 0

// ==== tests/bp_clk_gen.sv ====
`timescale 1ns/1ps

module bp_clk_gen #(
    parameter realtime HALF_PERIOD = 10.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tests/bp_props.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_props (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic                   stall_i,
    input logic                   squash_i,
    input logic                   pred_valid_o,
    input logic [`BP_VADDR_W-1:0] pred_start_o,
    input logic                   pred_redirect_o
);

    // an override is always a live prediction
    redirect_is_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pred_redirect_o |-> pred_valid_o
    ) else $error("redirect raised without a valid prediction");

    // pc is frozen while the stall lasts
    stall_holds_start: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (stall_i && !squash_i) ##1 stall_i |-> $stable(pred_start_o)
    ) else $error("start address moved during a stall");

    squash_clears_s2: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        squash_i |=> !pred_redirect_o
    ) else $error("redirect seen in the cycle after a squash");

endmodule

// ==== tests/bp_tb.sv ====
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RAND_CYCLES    = 1500;

    logic        clk;
    logic        arst_n;
    logic        stall;
    logic        squash;
    logic [31:0] squash_target;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic [31:0] upd_target;
    logic        upd_taken;
    logic        pred_valid_o;
    logic [31:0] pred_start_o;
    logic [31:0] pred_target_o;
    logic        pred_taken_o;
    logic        pred_redirect_o;

    // mirror state
    logic             m_started;
    logic [31:0]      m_pc;
    bp_pkg::bp_pred_t m_s2;
    logic             u_v   [8];
    logic [7:0]       u_tag [8];
    logic [31:0]      u_tgt [8];
    logic             b_v   [32];
    logic [9:0]       b_tag [32];
    logic [31:0]      b_tgt [32];
    logic [1:0]       b_ctr [32];

    logic             check_en;
    bp_pkg::bp_pred_t exp_pred;
    bp_pkg::bp_pred_t got_pred;
    int               pred_errors;
    int               bit_errors;
    int               cycles;
    logic [31:0]      seed;
    logic [31:0]      pool [12];
    logic [31:0]      r;
    logic [31:0]      r2;

    bp_clk_gen u_clk (.clk_o(clk));

    branch_predictor dut (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .stall_i         (stall),
        .squash_i        (squash),
        .squash_target_i (squash_target),
        .update_valid_i  (upd_valid),
        .update_pc_i     (upd_pc),
        .update_target_i (upd_target),
        .update_taken_i  (upd_taken),
        .pred_valid_o    (pred_valid_o),
        .pred_start_o    (pred_start_o),
        .pred_target_o   (pred_target_o),
        .pred_taken_o    (pred_taken_o),
        .pred_redirect_o (pred_redirect_o)
    );

    bind branch_predictor bp_props u_props (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall_i),
        .squash_i        (squash_i),
        .pred_valid_o    (pred_valid_o),
        .pred_start_o    (pred_start_o),
        .pred_redirect_o (pred_redirect_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bp_pkg::bp_pred_t s1_model();
        bp_pkg::bp_pred_t p;
        logic [2:0]       i;
        logic             hit;
        i   = m_pc[6:4];
        hit = u_v[i] && (u_tag[i] == m_pc[14:7]);
        p.valid      = m_started && !stall && !squash;
        p.start_addr = m_pc;
        p.target     = hit ? u_tgt[i] : m_pc + 32'd16;
        p.taken      = hit;
        p.redirect   = 1'b0;
        return p;
    endfunction

    function automatic bp_pkg::bp_pred_t s2_model();
        bp_pkg::bp_pred_t p;
        logic [4:0]       i;
        logic             hit;
        i   = m_s2.start_addr[8:4];
        hit = b_v[i] && (b_tag[i] == m_s2.start_addr[18:9]);
        p.valid      = m_s2.valid && !stall && !squash;
        p.start_addr = m_s2.start_addr;
        p.taken      = hit && b_ctr[i][1];
        p.target     = p.taken ? b_tgt[i] : m_s2.start_addr + 32'd16;
        p.redirect   = p.valid && (p.target != m_s2.target);
        return p;
    endfunction

    // expected output for the current state and inputs
    function automatic bp_pkg::bp_pred_t predict_model();
        bp_pkg::bp_pred_t p1;
        bp_pkg::bp_pred_t p2;
        p1 = s1_model();
        p2 = s2_model();
        return p2.redirect ? p2 : p1;
    endfunction

    task automatic reset_model();
        m_started = 1'b0;
        m_pc      = `BP_RESET_PC;
        m_s2      = '0;
        for (int i = 0; i < 8; i++) begin
            u_v[i]   = 1'b0;
            u_tag[i] = '0;
            u_tgt[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            b_v[i]   = 1'b0;
            b_tag[i] = '0;
            b_tgt[i] = '0;
            b_ctr[i] = '0;
        end
    endtask

    // state after the coming clock edge
    task automatic advance_model();
        bp_pkg::bp_pred_t p1;
        bp_pkg::bp_pred_t p2;
        logic [2:0]       ui;
        logic [4:0]       bi;
        logic             bhit;
        p1 = s1_model();
        p2 = s2_model();
        if (squash || p2.redirect) begin
            m_s2 = '0;
        end else if (!stall) begin
            m_s2 = p1;
        end
        if (squash) begin
            m_pc = squash_target;
        end else if (!(stall || !m_started)) begin
            m_pc = p2.redirect ? p2.target : p1.target;
        end
        m_started = 1'b1;
        ui = upd_pc[6:4];
        if (upd_valid && upd_taken) begin
            u_v[ui]   = 1'b1;
            u_tag[ui] = upd_pc[14:7];
            u_tgt[ui] = upd_target;
        end else if (upd_valid && u_tag[ui] == upd_pc[14:7]) begin
            u_v[ui] = 1'b0;
        end
        bi   = upd_pc[8:4];
        bhit = b_v[bi] && (b_tag[bi] == upd_pc[18:9]);
        if (upd_valid && bhit) begin
            if (upd_taken) begin
                b_tgt[bi] = upd_target;
                if (b_ctr[bi] != 2'd3) b_ctr[bi] = b_ctr[bi] + 2'd1;
            end else if (b_ctr[bi] != 2'd0) begin
                b_ctr[bi] = b_ctr[bi] - 2'd1;
            end
        end else if (upd_valid && upd_taken) begin
            b_v[bi]   = 1'b1;
            b_tag[bi] = upd_pc[18:9];
            b_tgt[bi] = upd_target;
            b_ctr[bi] = 2'd2;
        end
    endtask

    task automatic compare_pred(input bp_pkg::bp_pred_t exp, input bp_pkg::bp_pred_t got,
                                input string name);
        if (exp !== got) begin
            pred_errors++;
            $display("Error: %0d ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_bit(input logic exp, input logic got, input string name);
        if (exp !== got) begin
            bit_errors++;
            $display("Error: %0d ns %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            exp_pred = predict_model();
            got_pred = bp_pkg::bp_pred_t'({pred_valid_o, pred_start_o, pred_target_o,
                                           pred_taken_o, pred_redirect_o});
            compare_pred(exp_pred, got_pred, "pred");
            compare_bit(exp_pred.redirect, pred_redirect_o, "pred_redirect_o");
            advance_model();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic drive(input logic st, input logic sq, input logic [31:0] sq_tgt,
                         input logic uv, input logic [31:0] upc, input logic [31:0] utgt,
                         input logic utk);
        @(posedge clk);
        #2;
        stall         = st;
        squash        = sq;
        squash_target = sq_tgt;
        upd_valid     = uv;
        upd_pc        = upc;
        upd_target    = utgt;
        upd_taken     = utk;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) drive(0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic update(input logic [31:0] pc, input logic [31:0] tgt, input logic tk);
        drive(0, 0, 0, 1, pc, tgt, tk);
    endtask

    task automatic refetch(input logic [31:0] pc);
        drive(0, 1, pc, 0, 0, 0, 0);
    endtask

    initial begin
        arst_n = 1'b0;
        stall = 1'b0;
        squash = 1'b0;
        squash_target = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_target = '0;
        upd_taken = 1'b0;
        check_en = 1'b0;
        pred_errors = 0;
        bit_errors = 0;
        cycles = 0;
        seed = 32'h3a35;
        pool = '{32'h8000_0000, 32'h8000_0010, 32'h8000_0020, 32'h8000_0030,
                 32'h8000_0080, 32'h8000_00a0, 32'h8000_0200, 32'h8000_0210,
                 32'h8000_0400, 32'h8000_1080, 32'h8000_0100, 32'h8000_0060};
        reset_model();
        repeat (4) @(posedge clk);
        #2;
        arst_n   = 1'b1;
        check_en = 1'b1;

        // fall-through walk from the reset pc
        idle(8);
        // taken training, then refetch A
        update(32'h8000_0040, 32'h8000_0400, 1);
        refetch(32'h8000_0040);
        idle(4);
        // not taken drops the micro-BTB entry, counter goes to 1
        update(32'h8000_0040, 32'h8000_0400, 0);
        refetch(32'h8000_0040);
        idle(3);
        update(32'h8000_0040, 32'h8000_0400, 1);
        update(32'h8000_0040, 32'h8000_0400, 1);
        refetch(32'h8000_0040);
        idle(3);
        // B aliases A in the micro-BTB only, so stage 2 overrides
        update(32'h8000_00c0, 32'h8000_0800, 1);
        refetch(32'h8000_0040);
        idle(4);
        // stall with A's pending override held in stage 2, then squash it
        refetch(32'h8000_0040);
        idle(1);
        repeat (3) drive(1, 0, 0, 0, 0, 0, 0);
        drive(1, 1, 32'h8000_0200, 0, 0, 0, 0);
        idle(2);

        for (int k = 0; k < RAND_CYCLES; k++) begin
            seed = lcg_next(seed);
            r    = seed;
            seed = lcg_next(seed);
            r2   = seed;
            drive(r[18:16] == 3'd0, r[22:19] == 4'd0, pool[r[27:24] % 4'd12],
                  r2[17:16] == 2'd0, pool[r2[23:20] % 4'd12], pool[r2[27:24] % 4'd12],
                  r2[30]);
        end
        idle(3);
        check_en = 1'b0;

        $display("errors: %0d prediction mismatches, %0d bit mismatches",
                 pred_errors, bit_errors);
        if (pred_errors == 0 && bit_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
